/* verilog/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// --------------------
// tracker geometry
// --------------------

// one tracking entry per memory bank
`define ROB_N_BANK 4

// address bits that select the bank
`define ROB_BANK_LSB 6
`define ROB_BANK_MSB 7

// --------------------
// bus widths
// --------------------

// physical address
`define ROB_ADDR_W 32

// write and read data
`define ROB_DATA_W 64

// per-source tag, the source bit sits on top of it in the tid
`define ROB_TID_W 4

`endif

/* verilog/io_bus_pkg.sv */
`include "rob_params.svh"

package io_bus_pkg;

  // --------------------
  // request kind
  // --------------------
  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_type_e;

  // --------------------
  // transaction id
  // --------------------
  // src 0 => usb, src 1 => sdio
  typedef struct packed {
    logic                  src;
    logic [`ROB_TID_W-1:0] tag;
  } io_tid_t;

  // --------------------
  // request and response
  // --------------------
  typedef struct packed {
    req_type_e              req_type;
    logic [`ROB_ADDR_W-1:0] paddr;
    io_tid_t                tid;
    logic [`ROB_DATA_W-1:0] wdata;
  } io_req_t;

  // tid comes back unchanged from the noc
  typedef struct packed {
    io_tid_t                tid;
    logic [`ROB_DATA_W-1:0] rdata;
  } io_resp_t;

endpackage

/* verilog/rob_pkg.sv */
`include "rob_params.svh"

package rob_pkg;

  import io_bus_pkg::*;

  // --------------------
  // tracking entry
  // --------------------
  // one per bank, holds the tid of the outstanding read
  typedef struct packed {
    logic    vld;
    io_tid_t tid;
  } rob_entry_t;

  // one-hot rank among valid entries, bit 0 is the newest
  typedef logic [`ROB_N_BANK-1:0] age_vec_t;

  // bank number taken from the address
  typedef logic [`ROB_BANK_MSB-`ROB_BANK_LSB:0] bank_id_t;

endpackage

/* verilog/io_req_arbiter.sv */
`timescale 1ns/1ps

module io_req_arbiter
  import io_bus_pkg::*;
(
  input  logic           clk,
  input  logic           rstn,
  // peripheral requests from usb (0) and sdio (1)
  input  logic     [1:0] io_req_valid,
  input  io_req_t  [1:0] io_req,
  output logic     [1:0] io_req_ready,
  // merged stream towards the tracker
  output logic           merged_valid,
  output io_req_t        merged_req,
  input  logic           merged_ready,
  // noc response
  input  logic           noc_resp_valid,
  input  io_resp_t       noc_resp,
  output logic           noc_resp_ready,
  // responses back to the peripherals
  output logic     [1:0] io_resp_valid,
  output io_resp_t [1:0] io_resp,
  input  logic     [1:0] io_resp_ready
);

  // source that the search starts from
  logic rff_prio;
  logic nxt_prio;
  // grant kept over a stalled cycle
  logic rff_stall;
  logic rff_gnt;
  logic srch_src;
  logic gnt_src;
  logic req_accept;
  logic resp_src;

  // --------------------
  // request grant
  // --------------------

  // search starts at the pointer and falls over to the other source
  always_comb begin
    if (io_req_valid[rff_prio]) begin
      srch_src = rff_prio;
    end else begin
      srch_src = ~rff_prio;
    end
  end

  // a stalled grant stays on its source until the transfer
  assign gnt_src = (rff_stall & io_req_valid[rff_gnt]) ? rff_gnt : srch_src;

  assign merged_valid = |io_req_valid;
  assign req_accept   = merged_valid & merged_ready;

  // winner's payload with its port number in the src field
  always_comb begin
    merged_req         = io_req[gnt_src];
    merged_req.tid.src = gnt_src;
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      io_req_ready[i] = merged_ready & io_req_valid[i] & (gnt_src == 1'(i));
    end
  end

  // pointer moves past the winner only on an accepted transfer
  assign nxt_prio = req_accept ? ~gnt_src : rff_prio;

  always_ff @(posedge clk) begin
    if (~rstn) begin
      rff_prio  <= 1'b0;
      rff_stall <= 1'b0;
      rff_gnt   <= 1'b0;
    end else begin
      rff_prio  <= nxt_prio;
      rff_stall <= merged_valid & ~merged_ready;
      rff_gnt   <= gnt_src;
    end
  end

  // --------------------
  // response routing
  // --------------------

  assign resp_src = noc_resp.tid.src;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      io_resp_valid[i] = noc_resp_valid & (resp_src == 1'(i));
      // payload goes to both ports and valid picks the one
      io_resp[i]       = noc_resp;
    end
  end

  // ready of the addressed requester stays low while nothing is pending
  assign noc_resp_ready = noc_resp_valid & io_resp_ready[resp_src];

endmodule

/* verilog/read_order_tracker.sv */
`timescale 1ns/1ps
`include "rob_params.svh"

module read_order_tracker
  import io_bus_pkg::*;
  import rob_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  // merged request stream from the arbiter
  input  logic                   merged_valid,
  input  io_req_t                merged_req,
  output logic                   merged_ready,
  // request to the noc
  output logic                   noc_req_valid,
  output io_req_t                noc_req,
  input  logic                   noc_req_ready,
  // response handshake seen on the noc side
  input  logic                   noc_resp_valid,
  input  logic                   noc_resp_ready,
  input  io_tid_t                noc_resp_tid,
  // per-bank status
  output logic [`ROB_N_BANK-1:0] entry_vld_pbank,
  output logic [`ROB_N_BANK-1:0] is_oldest_pbank
);

  rob_entry_t [`ROB_N_BANK-1:0] rff_entry;
  rob_entry_t [`ROB_N_BANK-1:0] nxt_entry;
  age_vec_t   [`ROB_N_BANK-1:0] rff_age;
  age_vec_t   [`ROB_N_BANK-1:0] nxt_age;

  bank_id_t                     req_bank;
  logic                         req_is_read;
  logic                         req_hold;
  logic                         alloc_any;
  logic [`ROB_N_BANK-1:0]       alloc;
  logic [`ROB_N_BANK-1:0]       release_en;
  logic                         release_any;
  age_vec_t                     release_age;
  age_vec_t                     age_occupied;
  age_vec_t                     age_top;

  // --------------------
  // request path
  // --------------------

  assign req_bank    = merged_req.paddr[`ROB_BANK_MSB:`ROB_BANK_LSB];
  assign req_is_read = (merged_req.req_type == REQ_READ);

  // read to a busy bank waits for its response
  assign req_hold = merged_valid & req_is_read & rff_entry[req_bank].vld;

  assign noc_req_valid = merged_valid & ~req_hold;
  assign noc_req       = merged_req;
  assign merged_ready  = noc_req_ready & ~req_hold;

  assign alloc_any = noc_req_valid & noc_req_ready & req_is_read;

  // --------------------
  // allocate / release
  // --------------------

  always_comb begin
    for (int i = 0; i < `ROB_N_BANK; i++) begin
      alloc[i]      = alloc_any & (req_bank == bank_id_t'(i));
      // response tid matches the stored one
      release_en[i] = rff_entry[i].vld & noc_resp_valid & noc_resp_ready &
                      (noc_resp_tid == rff_entry[i].tid);
    end
  end

  assign release_any = |release_en;

  // rank of the freed entry, at most one per cycle
  always_comb begin
    release_age = '0;
    for (int i = 0; i < `ROB_N_BANK; i++) begin
      if (release_en[i]) begin
        release_age = rff_age[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `ROB_N_BANK; i++) begin
      nxt_entry[i] = rff_entry[i];
      nxt_age[i]   = rff_age[i];
      if (release_en[i]) begin
        nxt_entry[i].vld = 1'b0;
        nxt_age[i]       = '0;
      end else if (alloc[i]) begin
        nxt_entry[i].vld = 1'b1;
        nxt_entry[i].tid = merged_req.tid;
        // newest rank
        nxt_age[i]       = age_vec_t'(1);
      end else begin
        // others get one rank older on alloc, ranks above a freed one close up
        if (alloc_any) begin
          nxt_age[i] = nxt_age[i] << 1;
        end
        if (release_any && (rff_age[i] > release_age)) begin
          nxt_age[i] = nxt_age[i] >> 1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (~rstn) begin
      rff_entry <= '0;
      rff_age   <= '0;
    end else begin
      rff_entry <= nxt_entry;
      rff_age   <= nxt_age;
    end
  end

  // --------------------
  // status
  // --------------------

  always_comb begin
    age_occupied = '0;
    for (int i = 0; i < `ROB_N_BANK; i++) begin
      entry_vld_pbank[i] = rff_entry[i].vld;
      if (rff_entry[i].vld) begin
        age_occupied = age_occupied | rff_age[i];
      end
    end
  end

  // highest occupied rank is the oldest read
  always_comb begin
    age_top = '0;
    for (int i = 0; i < `ROB_N_BANK; i++) begin
      if (age_occupied[i]) begin
        age_top = age_vec_t'(1) << i;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `ROB_N_BANK; i++) begin
      is_oldest_pbank[i] = rff_entry[i].vld & (|(rff_age[i] & age_top));
    end
  end

endmodule

/* verilog/io_rob_top.sv */
`timescale 1ns/1ps
`include "rob_params.svh"

module io_rob_top
  import io_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  // usb / sdio requests, 0 => usb, 1 => sdio
  input  logic     [1:0]         io_req_valid,
  input  io_req_t  [1:0]         io_req,
  output logic     [1:0]         io_req_ready,
  // request to the noc
  output logic                   noc_req_valid,
  output io_req_t                noc_req,
  input  logic                   noc_req_ready,
  // response from the noc
  input  logic                   noc_resp_valid,
  input  io_resp_t               noc_resp,
  output logic                   noc_resp_ready,
  // responses to usb / sdio
  output logic     [1:0]         io_resp_valid,
  output io_resp_t [1:0]         io_resp,
  input  logic     [1:0]         io_resp_ready,
  // read age info for the noc
  output logic [`ROB_N_BANK-1:0] entry_vld_pbank,
  output logic [`ROB_N_BANK-1:0] is_oldest_pbank
);

  // merged stream between arbiter and tracker
  logic    merged_valid;
  logic    merged_ready;
  io_req_t merged_req;

  io_req_arbiter io_req_arbiter_inst (
    .clk            (clk),
    .rstn           (rstn),
    .io_req_valid   (io_req_valid),
    .io_req         (io_req),
    .io_req_ready   (io_req_ready),
    .merged_valid   (merged_valid),
    .merged_req     (merged_req),
    .merged_ready   (merged_ready),
    .noc_resp_valid (noc_resp_valid),
    .noc_resp       (noc_resp),
    .noc_resp_ready (noc_resp_ready),
    .io_resp_valid  (io_resp_valid),
    .io_resp        (io_resp),
    .io_resp_ready  (io_resp_ready)
  );

  // tracker only needs the response handshake and tid
  read_order_tracker read_order_tracker_inst (
    .clk             (clk),
    .rstn            (rstn),
    .merged_valid    (merged_valid),
    .merged_req      (merged_req),
    .merged_ready    (merged_ready),
    .noc_req_valid   (noc_req_valid),
    .noc_req         (noc_req),
    .noc_req_ready   (noc_req_ready),
    .noc_resp_valid  (noc_resp_valid),
    .noc_resp_ready  (noc_resp_ready),
    .noc_resp_tid    (noc_resp.tid),
    .entry_vld_pbank (entry_vld_pbank),
    .is_oldest_pbank (is_oldest_pbank)
  );

endmodule

/* testbench/tb_io_rob.sv */
`timescale 1ns/1ps
`include "rob_params.svh"

module tb_io_rob
  import io_bus_pkg::*;
();

  localparam int N_TAG = 1 << `ROB_TID_W;

  logic                   clk;
  logic                   rstn;
  logic     [1:0]         io_req_valid;
  io_req_t  [1:0]         io_req;
  logic     [1:0]         io_req_ready;
  logic                   noc_req_valid;
  io_req_t                noc_req;
  logic                   noc_req_ready;
  logic                   noc_resp_valid;
  io_resp_t               noc_resp;
  logic                   noc_resp_ready;
  logic     [1:0]         io_resp_valid;
  io_resp_t [1:0]         io_resp;
  logic     [1:0]         io_resp_ready;
  logic [`ROB_N_BANK-1:0] entry_vld_pbank;
  logic [`ROB_N_BANK-1:0] is_oldest_pbank;

  // requester state indexed by source (0 usb, 1 sdio)
  logic        req_on [2];
  logic        held [2];
  io_req_t     cur_req [2];
  logic        tag_busy [2][N_TAG];
  logic        tag_read [2][N_TAG];
  logic [31:0] tag_addr [2][N_TAG];
  // requests the noc model accepted and has not answered
  io_req_t     noc_q [$];
  logic        resp_on;
  io_resp_t    cur_resp;
  // reference model of the outstanding reads in issue order
  io_req_t     ref_q [$];
  // arbiter model with its pointer and stalled grant
  logic        prio;
  logic        stall;
  logic        gnt_last;

  logic [31:0] rng_state;
  logic        alt_mode;
  logic        issue_en;
  logic        have_last;
  logic        last_src;
  int          err_count;
  int          test_err;
  int          n_tests;
  int          n_fail;
  int          held_fwd;
  int          alt_checks;
  int          n_resp;

  io_rob_top io_rob_top_inst (.*);

  always #50 clk = ~clk;

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // noc memory contents seen by a read
  function automatic logic [63:0] read_data_of(input logic [31:0] addr);
    return {addr ^ 32'hc3a5_5a3c, ~addr + 32'd1};
  endfunction

  function automatic logic [`ROB_BANK_MSB-`ROB_BANK_LSB:0] bank_of(input io_req_t r);
    return r.paddr[`ROB_BANK_MSB:`ROB_BANK_LSB];
  endfunction

  function automatic logic traffic_pending();
    return req_on[0] || req_on[1] || resp_on || (noc_q.size() > 0);
  endfunction

  task automatic report_error(input string msg);
    err_count++;
    test_err++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (test_err != 0) begin
      n_fail++;
    end
    $display("test %s: %s, %0d errors", name, (test_err == 0) ? "pass" : "fail", test_err);
    test_err = 0;
  endtask

  task automatic check_idle();
    if (noc_req_valid !== 1'b0 || io_resp_valid !== 2'b00 || noc_resp_ready !== 1'b0 ||
        entry_vld_pbank !== '0 || is_oldest_pbank !== '0) begin
      report_error("outputs not idle around reset");
    end
  endtask

  // new request with a tag free for this source
  task automatic start_request(input int s);
    logic [31:0] r;
    logic [3:0]  t;
    r = next_rand();
    t = r[3:0];
    for (int k = 0; k < N_TAG && tag_busy[s][t]; k++) begin
      t = t + 4'd1;
    end
    if (!tag_busy[s][t]) begin
      cur_req[s].req_type = (alt_mode || r[4]) ? REQ_WRITE : REQ_READ;
      cur_req[s].paddr    = next_rand();
      // src is overwritten by the arbiter
      cur_req[s].tid.src  = r[5];
      cur_req[s].tid.tag  = t;
      cur_req[s].wdata    = {next_rand(), next_rand()};
      tag_busy[s][t] = 1'b1;
      tag_read[s][t] = (cur_req[s].req_type == REQ_READ);
      tag_addr[s][t] = cur_req[s].paddr;
      req_on[s] = 1'b1;
      held[s]   = 1'b0;
    end
  endtask

  // --------------------
  // one clock cycle
  // --------------------

  task automatic run_cycle();
    logic [31:0]            r;
    int                     idx;
    int                     n_acc;
    int                     src;
    logic [`ROB_N_BANK-1:0] exp_vld;
    logic [`ROB_N_BANK-1:0] exp_old;
    io_req_t                exp_req;
    io_resp_t               got;
    logic                   gnt;
    logic                   exp_nv;
    logic                   exp_acc;
    logic [1:0]             exp_rdy;
    @(negedge clk);
    r = next_rand();
    for (int s = 0; s < 2; s++) begin
      if (!req_on[s] && issue_en && (alt_mode || r[s])) begin
        start_request(s);
      end
      io_req_valid[s] = req_on[s];
      io_req[s]       = cur_req[s];
    end
    noc_req_ready    = alt_mode || (r[3:2] != 2'b00);
    io_resp_ready[0] = alt_mode || (r[5:4] != 2'b00);
    io_resp_ready[1] = alt_mode || (r[7:6] != 2'b00);
    // answer an outstanding request after a random delay and in random order
    if (!resp_on && noc_q.size() > 0 && (alt_mode || r[9:8] == 2'b00)) begin
      idx = int'(next_rand() % 32'(noc_q.size()));
      cur_resp.tid   = noc_q[idx].tid;
      cur_resp.rdata = (noc_q[idx].req_type == REQ_READ) ? read_data_of(noc_q[idx].paddr) : '0;
      noc_q.delete(idx);
      resp_on = 1'b1;
    end
    noc_resp_valid = resp_on;
    noc_resp       = cur_resp;
    #10;
    exp_vld = '0;
    exp_old = '0;
    foreach (ref_q[i]) begin
      exp_vld[bank_of(ref_q[i])] = 1'b1;
    end
    if (ref_q.size() > 0) begin
      exp_old[bank_of(ref_q[0])] = 1'b1;
    end
    if (entry_vld_pbank !== exp_vld) begin
      report_error($sformatf("entry_vld_pbank %b, expected %b", entry_vld_pbank, exp_vld));
    end
    if (is_oldest_pbank !== exp_old) begin
      report_error($sformatf("is_oldest_pbank %b, expected %b", is_oldest_pbank, exp_old));
    end
    // expected grant, a stalled one stays on its source
    if (stall && io_req_valid[gnt_last]) begin
      gnt = gnt_last;
    end else if (io_req_valid[prio]) begin
      gnt = prio;
    end else begin
      gnt = ~prio;
    end
    exp_req         = cur_req[gnt];
    exp_req.tid.src = gnt;
    exp_nv  = io_req_valid[gnt] &&
              !(exp_req.req_type == REQ_READ && exp_vld[bank_of(exp_req)]);
    exp_acc = exp_nv && noc_req_ready;
    exp_rdy = exp_acc ? (2'b01 << gnt) : 2'b00;
    // request transfer at the coming edge
    n_acc = 0;
    src   = 0;
    for (int s = 0; s < 2; s++) begin
      if (req_on[s] && cur_req[s].req_type == REQ_READ && exp_vld[bank_of(cur_req[s])]) begin
        held[s] = 1'b1;
      end
      if (io_req_valid[s] && io_req_ready[s]) begin
        n_acc++;
        src = s;
      end
    end
    if (noc_req_valid !== exp_nv || io_req_ready !== exp_rdy) begin
      report_error($sformatf("noc_req_valid %b io_req_ready %b, expected %b %b",
                             noc_req_valid, io_req_ready, exp_nv, exp_rdy));
    end else if (exp_nv && noc_req !== exp_req) begin
      report_error($sformatf("noc_req %h, expected %h", noc_req, exp_req));
    end
    if (noc_req_valid && noc_req_ready && noc_req.req_type == REQ_READ &&
        exp_vld[bank_of(noc_req)]) begin
      report_error($sformatf("second read to busy bank %0d", bank_of(noc_req)));
    end
    if (n_acc == 1) begin
      if (alt_mode && io_req_valid == 2'b11) begin
        alt_checks++;
        if (have_last && src[0] == last_src) begin
          report_error($sformatf("source %0d granted twice in a row", src));
        end
      end
      have_last = 1'b1;
      last_src  = src[0];
    end
    if (exp_acc) begin
      if (exp_req.req_type == REQ_READ) begin
        ref_q.push_back(exp_req);
        if (held[gnt]) begin
          held_fwd++;
        end
      end
      noc_q.push_back(exp_req);
      req_on[gnt] = 1'b0;
      prio        = ~gnt;
    end
    stall    = (io_req_valid != 2'b00) && !exp_acc;
    gnt_last = gnt;
    // response routing
    if (resp_on) begin
      src = int'(cur_resp.tid.src);
      if (io_resp_valid !== (2'b01 << src) || noc_resp_ready !== io_resp_ready[src]) begin
        report_error($sformatf("response to source %0d, io_resp_valid %b noc_resp_ready %b",
                               src, io_resp_valid, noc_resp_ready));
      end
      if (noc_resp_ready) begin
        got = io_resp[src];
        if (got.tid !== cur_resp.tid || !tag_busy[src][got.tid.tag]) begin
          report_error($sformatf("response tid %h not outstanding", got.tid));
        end else if (tag_read[src][got.tid.tag] &&
                     got.rdata !== read_data_of(tag_addr[src][got.tid.tag])) begin
          report_error($sformatf("read data %h, expected %h", got.rdata,
                                 read_data_of(tag_addr[src][got.tid.tag])));
        end
        tag_busy[src][cur_resp.tid.tag] = 1'b0;
        for (int i = 0; i < ref_q.size(); i++) begin
          if (ref_q[i].tid == cur_resp.tid) begin
            ref_q.delete(i);
            break;
          end
        end
        resp_on = 1'b0;
        n_resp++;
      end
    end else if (io_resp_valid !== 2'b00 || noc_resp_ready !== 1'b0) begin
      report_error("response valid or ready without a noc response");
    end
  endtask

  task automatic drain(input int limit);
    int n;
    issue_en = 1'b0;
    n = 0;
    while (traffic_pending() && n < limit) begin
      run_cycle();
      n++;
    end
    if (traffic_pending()) begin
      err_count++;
      test_err++;
      $display("timeout: requests still outstanding after %0d cycles", limit);
    end
    // entries must read empty afterwards
    run_cycle();
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    clk            = 1'b0;
    rstn           = 1'b0;
    io_req_valid   = '0;
    io_req         = '0;
    noc_req_ready  = 1'b0;
    noc_resp_valid = 1'b0;
    noc_resp       = '0;
    io_resp_ready  = '0;
    rng_state      = 32'h2fb2_f147;
    {alt_mode, issue_en, have_last, last_src, resp_on} = '0;
    {prio, stall, gnt_last} = '0;
    {err_count, test_err, n_tests, n_fail} = '0;
    {held_fwd, alt_checks, n_resp} = '0;
    cur_resp = '0;
    for (int s = 0; s < 2; s++) begin
      req_on[s]  = 1'b0;
      held[s]    = 1'b0;
      cur_req[s] = '0;
      for (int t = 0; t < N_TAG; t++) begin
        tag_busy[s][t] = 1'b0;
        tag_read[s][t] = 1'b0;
        tag_addr[s][t] = '0;
      end
    end

    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_idle();
    end
    rstn = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle();
    end
    end_test("reset_values");

    issue_en = 1'b1;
    for (int i = 0; i < 4000; i++) begin
      run_cycle();
    end
    drain(2000);
    if (held_fwd == 0 || n_resp == 0) begin
      err_count++;
      test_err++;
      $display("random traffic never forwarded a held read");
    end
    end_test("random_traffic");

    // both sources always valid and the noc always ready
    alt_mode  = 1'b1;
    have_last = 1'b0;
    issue_en  = 1'b1;
    for (int i = 0; i < 400; i++) begin
      run_cycle();
    end
    drain(200);
    if (alt_checks == 0) begin
      err_count++;
      test_err++;
      $display("no cycle had both sources valid");
    end
    end_test("alternation");

    $display("%0d tests run, %0d failed, %0d errors", n_tests, n_fail, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+verilog
verilog/io_bus_pkg.sv
verilog/rob_pkg.sv
verilog/io_req_arbiter.sv
verilog/read_order_tracker.sv
verilog/io_rob_top.sv
testbench/tb_io_rob.sv

/* Makefile */
# Verilator build and run of the I/O read-ordering testbench

VERILATOR ?= verilator
TOP       ?= tb_io_rob
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
